// File: common/axi_xbar_pkg.sv
// Response codes, default widths and index helper shared by the read crossbar RTL
package axi_xbar_pkg;

  // AXI read response code
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_DECERR = 2'd3;

  // Default port counts
  localparam int DEF_NB_INIT = 2;
  localparam int DEF_NB_TARG = 2;

  // Default bus widths
  localparam int DEF_ADDR_W = 32;
  localparam int DEF_DATA_W = 32;
  localparam int DEF_ID_W   = 4;

  // Bits needed for a port index, never less than one
  function automatic int idx_width(input int nb_ports);
    int width;
    width = 1;
    if (nb_ports > 2)
    begin
      width = $clog2(nb_ports);
    end
    return width;
  endfunction

endpackage

// File: common/axi_read_if.sv
// AR and R channel bundle for one read link, with modports for each side of the link
`timescale 1ns/10ps

interface axi_read_if #(
  parameter int ID_W   = axi_xbar_pkg::DEF_ID_W,
  parameter int ADDR_W = axi_xbar_pkg::DEF_ADDR_W,
  parameter int DATA_W = axi_xbar_pkg::DEF_DATA_W
);
  import axi_xbar_pkg::*;

  // Read address channel
  logic [ID_W-1:0]   ar_id;
  logic [ADDR_W-1:0] ar_addr;
  logic              ar_valid;
  logic              ar_ready;

  // Read data channel, single beat
  logic [ID_W-1:0]   r_id;
  logic [DATA_W-1:0] r_data;
  resp_t             r_resp;
  logic              r_valid;
  logic              r_ready;

  modport ar_src  (output ar_id, ar_addr, ar_valid, input ar_ready);
  modport ar_sink (input ar_id, ar_addr, ar_valid, output ar_ready);

  modport r_sink  (input r_id, r_data, r_resp, r_valid, output r_ready);
  modport r_src   (output r_id, r_data, r_resp, r_valid, input r_ready);

endinterface

// File: request_path/addr_decoder.sv
// Combinational range match of one read address against every target window
`timescale 1ns/10ps

module addr_decoder #(
  parameter int NB_TARG = axi_xbar_pkg::DEF_NB_TARG,
  parameter int ADDR_W  = axi_xbar_pkg::DEF_ADDR_W
) (
  input  logic [ADDR_W-1:0]              addr_i,
  input  logic [NB_TARG-1:0][ADDR_W-1:0] start_addr_i,
  input  logic [NB_TARG-1:0][ADDR_W-1:0] end_addr_i,
  output logic [NB_TARG-1:0]             sel_o,
  output logic                           miss_o
);

  logic [NB_TARG-1:0] hit;

  // Both bounds inclusive
  always_comb
  begin
    for (int k = 0; k < NB_TARG; k++)
    begin
      hit[k] = (addr_i >= start_addr_i[k]) && (addr_i <= end_addr_i[k]);
    end
  end

  // Keep only the lowest set bit so overlapping windows resolve to the lower target
  assign sel_o = hit & (~hit + NB_TARG'(1));

  assign miss_o = ~|hit;

endmodule

// File: hdl/rr_arbiter.sv
// Round-robin arbiter feeding a one-entry output register, generic over the payload type
`timescale 1ns/10ps

module rr_arbiter #(
  parameter int  NB_REQ    = 2,
  parameter type payload_t = logic
) (
  input  logic              clk,
  input  logic              reset_i,
  input  logic [NB_REQ-1:0] req_valid_i,
  input  payload_t          req_payload_i [NB_REQ],
  output logic [NB_REQ-1:0] req_ready_o,
  output payload_t          out_payload_o,
  output logic              out_valid_o,
  input  logic              out_ready_i
);
  import axi_xbar_pkg::*;

  localparam int PTR_W = idx_width(NB_REQ);

  logic [PTR_W-1:0] ptr_q;
  logic [PTR_W-1:0] win_idx;
  logic             win_found;
  logic             take;

  // First valid requester at or after the pointer
  always_comb
  begin
    int cand;
    win_found = 1'b0;
    win_idx   = '0;
    for (int n = 0; n < NB_REQ; n++)
    begin
      cand = (int'(ptr_q) + n) % NB_REQ;
      if (!win_found && req_valid_i[cand])
      begin
        win_found = 1'b1;
        win_idx   = PTR_W'(cand);
      end
    end
  end

  // Register can take a new entry when empty or emptying this cycle
  assign take = win_found && (!out_valid_o || out_ready_i);

  always_comb
  begin
    req_ready_o = '0;
    if (take)
    begin
      req_ready_o[win_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      out_valid_o <= 1'b0;
      ptr_q       <= '0;
    end
    else if (take)
    begin
      out_valid_o <= 1'b1;
      ptr_q       <= (win_idx == PTR_W'(NB_REQ - 1)) ? '0 : win_idx + 1'b1;
    end
    else if (out_ready_i)
    begin
      out_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      out_payload_o <= req_payload_i[win_idx];
    end
  end

endmodule

// File: request_path/ar_request_path.sv
// AR side of the crossbar, decoding each initiator and arbitrating per target with ID widening
`timescale 1ns/10ps

module ar_request_path #(
  parameter int NB_INIT = axi_xbar_pkg::DEF_NB_INIT,
  parameter int NB_TARG = axi_xbar_pkg::DEF_NB_TARG,
  parameter int ADDR_W  = axi_xbar_pkg::DEF_ADDR_W,
  parameter int ID_W    = axi_xbar_pkg::DEF_ID_W
) (
  input  logic                           clk,
  input  logic                           reset_i,
  input  logic [NB_TARG-1:0][ADDR_W-1:0] start_addr_i,
  input  logic [NB_TARG-1:0][ADDR_W-1:0] end_addr_i,
  axi_read_if.ar_sink                    init_ar [NB_INIT],
  axi_read_if.ar_src                     targ_ar [NB_TARG],
  output logic [NB_INIT-1:0]             err_valid_o,
  output logic [NB_INIT-1:0][ID_W-1:0]   err_id_o,
  input  logic [NB_INIT-1:0]             err_ready_i
);
  import axi_xbar_pkg::*;

  localparam int EXT_W = idx_width(NB_INIT);
  localparam int WID_W = ID_W + EXT_W;

  typedef struct packed {
    logic [WID_W-1:0]  id;
    logic [ADDR_W-1:0] addr;
  } ar_req_t;

  logic [NB_INIT-1:0]              ar_valid;
  logic [NB_INIT-1:0][ADDR_W-1:0]  ar_addr;
  logic [NB_INIT-1:0][ID_W-1:0]    ar_id;
  logic [NB_INIT-1:0][NB_TARG-1:0] sel;
  logic [NB_INIT-1:0]              miss;
  ar_req_t                         req [NB_INIT];
  logic [NB_TARG-1:0][NB_INIT-1:0] tgt_valid;
  logic [NB_TARG-1:0][NB_INIT-1:0] tgt_ready;
  logic [NB_INIT-1:0][NB_TARG-1:0] init_grant;
  ar_req_t                         tgt_out [NB_TARG];
  logic [NB_TARG-1:0]              tgt_out_valid;

  for (genvar i = 0; i < NB_INIT; i++)
  begin : g_init
    assign ar_valid[i] = init_ar[i].ar_valid;
    assign ar_addr[i]  = init_ar[i].ar_addr;
    assign ar_id[i]    = init_ar[i].ar_id;

    addr_decoder #(
      .NB_TARG (NB_TARG),
      .ADDR_W  (ADDR_W)
    ) u_dec (
      .addr_i       (ar_addr[i]),
      .start_addr_i (start_addr_i),
      .end_addr_i   (end_addr_i),
      .sel_o        (sel[i]),
      .miss_o       (miss[i])
    );

    // Initiator index goes above the original ID
    assign req[i] = '{id: {EXT_W'(i), ar_id[i]}, addr: ar_addr[i]};

    assign err_valid_o[i] = ar_valid[i] & miss[i];
    assign err_id_o[i]    = ar_id[i];

    for (genvar k = 0; k < NB_TARG; k++)
    begin : g_sel
      assign tgt_valid[k][i]  = ar_valid[i] & sel[i][k];
      assign init_grant[i][k] = tgt_ready[k][i];
    end

    assign init_ar[i].ar_ready = miss[i] ? err_ready_i[i] : |init_grant[i];
  end

  for (genvar k = 0; k < NB_TARG; k++)
  begin : g_targ
    rr_arbiter #(
      .NB_REQ    (NB_INIT),
      .payload_t (ar_req_t)
    ) u_arb (
      .clk           (clk),
      .reset_i       (reset_i),
      .req_valid_i   (tgt_valid[k]),
      .req_payload_i (req),
      .req_ready_o   (tgt_ready[k]),
      .out_payload_o (tgt_out[k]),
      .out_valid_o   (tgt_out_valid[k]),
      .out_ready_i   (targ_ar[k].ar_ready)
    );

    assign targ_ar[k].ar_id    = tgt_out[k].id;
    assign targ_ar[k].ar_addr  = tgt_out[k].addr;
    assign targ_ar[k].ar_valid = tgt_out_valid[k];
  end

endmodule

// File: hdl/decerr_responder.sv
// Holds one unmapped read per initiator until its error response is taken
`timescale 1ns/10ps

module decerr_responder #(
  parameter int NB_INIT = axi_xbar_pkg::DEF_NB_INIT,
  parameter int ID_W    = axi_xbar_pkg::DEF_ID_W
) (
  input  logic                         clk,
  input  logic                         reset_i,
  input  logic [NB_INIT-1:0]           err_valid_i,
  input  logic [NB_INIT-1:0][ID_W-1:0] err_id_i,
  output logic [NB_INIT-1:0]           err_ready_o,
  output logic [NB_INIT-1:0]           rsp_valid_o,
  output logic [NB_INIT-1:0][ID_W-1:0] rsp_id_o,
  input  logic [NB_INIT-1:0]           rsp_ready_i
);

  // Free slot, or the held response leaves this cycle
  assign err_ready_o = ~rsp_valid_o | rsp_ready_i;

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      rsp_valid_o <= '0;
    end
    else
    begin
      for (int i = 0; i < NB_INIT; i++)
      begin
        if (err_valid_i[i] && err_ready_o[i])
        begin
          rsp_valid_o[i] <= 1'b1;
        end
        else if (rsp_ready_i[i])
        begin
          rsp_valid_o[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < NB_INIT; i++)
    begin
      if (err_valid_i[i] && err_ready_o[i])
      begin
        rsp_id_o[i] <= err_id_i[i];
      end
    end
  end

endmodule

// File: hdl/r_response_merge.sv
// R side of the crossbar, steering target and error responses back to initiators by ID extension
`timescale 1ns/10ps

module r_response_merge #(
  parameter int NB_INIT = axi_xbar_pkg::DEF_NB_INIT,
  parameter int NB_TARG = axi_xbar_pkg::DEF_NB_TARG,
  parameter int DATA_W  = axi_xbar_pkg::DEF_DATA_W,
  parameter int ID_W    = axi_xbar_pkg::DEF_ID_W
) (
  input  logic                         clk,
  input  logic                         reset_i,
  axi_read_if.r_sink                   targ_r [NB_TARG],
  input  logic [NB_INIT-1:0]           err_valid_i,
  input  logic [NB_INIT-1:0][ID_W-1:0] err_id_i,
  output logic [NB_INIT-1:0]           err_ready_o,
  axi_read_if.r_src                    init_r [NB_INIT]
);
  import axi_xbar_pkg::*;

  localparam int EXT_W = idx_width(NB_INIT);
  localparam int WID_W = ID_W + EXT_W;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    resp_t             resp;
  } r_rsp_t;

  logic [NB_TARG-1:0]              t_valid;
  logic [NB_TARG-1:0][WID_W-1:0]   t_id;
  logic [NB_TARG-1:0][EXT_W-1:0]   t_dst;
  r_rsp_t                          t_rsp [NB_TARG];
  logic [NB_TARG-1:0][NB_INIT-1:0] t_grant;
  logic [NB_INIT-1:0][NB_TARG:0]   req_valid;
  logic [NB_INIT-1:0][NB_TARG:0]   req_ready;
  r_rsp_t                          req_rsp [NB_INIT][NB_TARG+1];
  r_rsp_t                          out_rsp [NB_INIT];
  logic [NB_INIT-1:0]              out_valid;

  for (genvar k = 0; k < NB_TARG; k++)
  begin : g_targ
    assign t_valid[k] = targ_r[k].r_valid;
    assign t_id[k]    = targ_r[k].r_id;
    assign t_dst[k]   = t_id[k][WID_W-1:ID_W];
    // Extension bits are dropped before the response leaves
    assign t_rsp[k]   = '{id: t_id[k][ID_W-1:0], data: targ_r[k].r_data, resp: targ_r[k].r_resp};
    assign targ_r[k].r_ready = |t_grant[k];
  end

  for (genvar i = 0; i < NB_INIT; i++)
  begin : g_init
    for (genvar k = 0; k < NB_TARG; k++)
    begin : g_src
      assign req_valid[i][k] = t_valid[k] && (t_dst[k] == EXT_W'(i));
      assign req_rsp[i][k]   = t_rsp[k];
      assign t_grant[k][i]   = req_ready[i][k];
    end

    // Error responder takes the last requester slot
    assign req_valid[i][NB_TARG] = err_valid_i[i];
    assign req_rsp[i][NB_TARG]   = '{id: err_id_i[i], data: '0, resp: RESP_DECERR};
    assign err_ready_o[i]        = req_ready[i][NB_TARG];

    rr_arbiter #(
      .NB_REQ    (NB_TARG + 1),
      .payload_t (r_rsp_t)
    ) u_arb (
      .clk           (clk),
      .reset_i       (reset_i),
      .req_valid_i   (req_valid[i]),
      .req_payload_i (req_rsp[i]),
      .req_ready_o   (req_ready[i]),
      .out_payload_o (out_rsp[i]),
      .out_valid_o   (out_valid[i]),
      .out_ready_i   (init_r[i].r_ready)
    );

    assign init_r[i].r_id    = out_rsp[i].id;
    assign init_r[i].r_data  = out_rsp[i].data;
    assign init_r[i].r_resp  = out_rsp[i].resp;
    assign init_r[i].r_valid = out_valid[i];
  end

endmodule

// File: hdl/axi_read_xbar.sv
// Read-only AXI crossbar top, routing initiator reads to targets by configurable address ranges
`timescale 1ns/10ps

module axi_read_xbar #(
  parameter int NB_INIT  = axi_xbar_pkg::DEF_NB_INIT,
  parameter int NB_TARG  = axi_xbar_pkg::DEF_NB_TARG,
  parameter int ADDR_W   = axi_xbar_pkg::DEF_ADDR_W,
  parameter int DATA_W   = axi_xbar_pkg::DEF_DATA_W,
  parameter int ID_W     = axi_xbar_pkg::DEF_ID_W,
  localparam int WID_W   = ID_W + axi_xbar_pkg::idx_width(NB_INIT)
) (
  input  logic                                  clk,
  input  logic                                  reset_i,
  input  logic [NB_TARG-1:0][ADDR_W-1:0]        start_addr_i,
  input  logic [NB_TARG-1:0][ADDR_W-1:0]        end_addr_i,
  input  logic [NB_INIT-1:0][ID_W-1:0]          init_ar_id_i,
  input  logic [NB_INIT-1:0][ADDR_W-1:0]        init_ar_addr_i,
  input  logic [NB_INIT-1:0]                    init_ar_valid_i,
  output logic [NB_INIT-1:0]                    init_ar_ready_o,
  output logic [NB_INIT-1:0][ID_W-1:0]          init_r_id_o,
  output logic [NB_INIT-1:0][DATA_W-1:0]        init_r_data_o,
  output axi_xbar_pkg::resp_t [NB_INIT-1:0]     init_r_resp_o,
  output logic [NB_INIT-1:0]                    init_r_valid_o,
  input  logic [NB_INIT-1:0]                    init_r_ready_i,
  output logic [NB_TARG-1:0][WID_W-1:0]         targ_ar_id_o,
  output logic [NB_TARG-1:0][ADDR_W-1:0]        targ_ar_addr_o,
  output logic [NB_TARG-1:0]                    targ_ar_valid_o,
  input  logic [NB_TARG-1:0]                    targ_ar_ready_i,
  input  logic [NB_TARG-1:0][WID_W-1:0]         targ_r_id_i,
  input  logic [NB_TARG-1:0][DATA_W-1:0]        targ_r_data_i,
  input  axi_xbar_pkg::resp_t [NB_TARG-1:0]     targ_r_resp_i,
  input  logic [NB_TARG-1:0]                    targ_r_valid_i,
  output logic [NB_TARG-1:0]                    targ_r_ready_o
);

  axi_read_if #(.ID_W(ID_W), .ADDR_W(ADDR_W), .DATA_W(DATA_W)) init_bus [NB_INIT] ();
  axi_read_if #(.ID_W(WID_W), .ADDR_W(ADDR_W), .DATA_W(DATA_W)) targ_bus [NB_TARG] ();

  // Miss path from the request side through the error holders
  logic [NB_INIT-1:0]           err_valid;
  logic [NB_INIT-1:0]           err_ready;
  logic [NB_INIT-1:0][ID_W-1:0] err_id;
  logic [NB_INIT-1:0]           rsp_valid;
  logic [NB_INIT-1:0]           rsp_ready;
  logic [NB_INIT-1:0][ID_W-1:0] rsp_id;

  for (genvar i = 0; i < NB_INIT; i++)
  begin : g_init
    assign init_bus[i].ar_id    = init_ar_id_i[i];
    assign init_bus[i].ar_addr  = init_ar_addr_i[i];
    assign init_bus[i].ar_valid = init_ar_valid_i[i];
    assign init_ar_ready_o[i]   = init_bus[i].ar_ready;
    assign init_r_id_o[i]       = init_bus[i].r_id;
    assign init_r_data_o[i]     = init_bus[i].r_data;
    assign init_r_resp_o[i]     = init_bus[i].r_resp;
    assign init_r_valid_o[i]    = init_bus[i].r_valid;
    assign init_bus[i].r_ready  = init_r_ready_i[i];
  end

  for (genvar k = 0; k < NB_TARG; k++)
  begin : g_targ
    assign targ_ar_id_o[k]      = targ_bus[k].ar_id;
    assign targ_ar_addr_o[k]    = targ_bus[k].ar_addr;
    assign targ_ar_valid_o[k]   = targ_bus[k].ar_valid;
    assign targ_bus[k].ar_ready = targ_ar_ready_i[k];
    assign targ_bus[k].r_id     = targ_r_id_i[k];
    assign targ_bus[k].r_data   = targ_r_data_i[k];
    assign targ_bus[k].r_resp   = targ_r_resp_i[k];
    assign targ_bus[k].r_valid  = targ_r_valid_i[k];
    assign targ_r_ready_o[k]    = targ_bus[k].r_ready;
  end

  ar_request_path #(
    .NB_INIT (NB_INIT),
    .NB_TARG (NB_TARG),
    .ADDR_W  (ADDR_W),
    .ID_W    (ID_W)
  ) u_ar_path (
    .clk          (clk),
    .reset_i      (reset_i),
    .start_addr_i (start_addr_i),
    .end_addr_i   (end_addr_i),
    .init_ar      (init_bus),
    .targ_ar      (targ_bus),
    .err_valid_o  (err_valid),
    .err_id_o     (err_id),
    .err_ready_i  (err_ready)
  );

  decerr_responder #(
    .NB_INIT (NB_INIT),
    .ID_W    (ID_W)
  ) u_decerr (
    .clk         (clk),
    .reset_i     (reset_i),
    .err_valid_i (err_valid),
    .err_id_i    (err_id),
    .err_ready_o (err_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_id_o    (rsp_id),
    .rsp_ready_i (rsp_ready)
  );

  r_response_merge #(
    .NB_INIT (NB_INIT),
    .NB_TARG (NB_TARG),
    .DATA_W  (DATA_W),
    .ID_W    (ID_W)
  ) u_r_merge (
    .clk         (clk),
    .reset_i     (reset_i),
    .targ_r      (targ_bus),
    .err_valid_i (rsp_valid),
    .err_id_i    (rsp_id),
    .err_ready_o (rsp_ready),
    .init_r      (init_bus)
  );

endmodule

// File: verif/axi_read_xbar_asserts.sv
// Protocol assertions bound to the read crossbar top for handshake and reset rules
`timescale 1ns/10ps

module axi_read_xbar_asserts #(
  parameter int NB_INIT = axi_xbar_pkg::DEF_NB_INIT,
  parameter int NB_TARG = axi_xbar_pkg::DEF_NB_TARG,
  parameter int ADDR_W  = axi_xbar_pkg::DEF_ADDR_W,
  parameter int DATA_W  = axi_xbar_pkg::DEF_DATA_W,
  parameter int ID_W    = axi_xbar_pkg::DEF_ID_W,
  localparam int WID_W  = ID_W + axi_xbar_pkg::idx_width(NB_INIT)
) (
  input logic                              clk,
  input logic                              reset_i,
  input logic [NB_TARG-1:0][ADDR_W-1:0]    start_addr_i,
  input logic [NB_TARG-1:0][ADDR_W-1:0]    end_addr_i,
  input logic [NB_INIT-1:0][ID_W-1:0]      init_r_id_o,
  input logic [NB_INIT-1:0][DATA_W-1:0]    init_r_data_o,
  input axi_xbar_pkg::resp_t [NB_INIT-1:0] init_r_resp_o,
  input logic [NB_INIT-1:0]                init_r_valid_o,
  input logic [NB_INIT-1:0]                init_r_ready_i,
  input logic [NB_TARG-1:0][WID_W-1:0]     targ_ar_id_o,
  input logic [NB_TARG-1:0][ADDR_W-1:0]    targ_ar_addr_o,
  input logic [NB_TARG-1:0]                targ_ar_valid_o,
  input logic [NB_TARG-1:0]                targ_ar_ready_i
);

  int                 fail_count = 0;
  logic [NB_TARG-1:0] in_own_window;

  // Window of target k holds the address and no lower window does
  always_comb
  begin
    for (int k = 0; k < NB_TARG; k++)
    begin
      in_own_window[k] = (targ_ar_addr_o[k] >= start_addr_i[k])
                         && (targ_ar_addr_o[k] <= end_addr_i[k]);
      for (int j = 0; j < k; j++)
      begin
        if ((targ_ar_addr_o[k] >= start_addr_i[j]) && (targ_ar_addr_o[k] <= end_addr_i[j]))
        begin
          in_own_window[k] = 1'b0;
        end
      end
    end
  end

  for (genvar i = 0; i < NB_INIT; i++)
  begin : g_init
    r_hold: assert property (@(posedge clk) disable iff (reset_i)
      init_r_valid_o[i] && !init_r_ready_i[i] |=> init_r_valid_o[i]
        && $stable(init_r_id_o[i]) && $stable(init_r_data_o[i]) && $stable(init_r_resp_o[i]))
      else
      begin
        fail_count++;
        $error("init R port %0d dropped or changed a response before ready", i);
      end
  end

  for (genvar k = 0; k < NB_TARG; k++)
  begin : g_targ
    ar_hold: assert property (@(posedge clk) disable iff (reset_i)
      targ_ar_valid_o[k] && !targ_ar_ready_i[k] |=> targ_ar_valid_o[k]
        && $stable(targ_ar_id_o[k]) && $stable(targ_ar_addr_o[k]))
      else
      begin
        fail_count++;
        $error("target AR port %0d dropped or changed a request before ready", k);
      end

    // A request on a target decodes to that target alone
    ar_route: assert property (@(posedge clk) disable iff (reset_i)
      targ_ar_valid_o[k] |-> in_own_window[k])
      else
      begin
        fail_count++;
        $error("target AR port %0d carries an address outside its own window", k);
      end
  end

  reset_quiet: assert property (@(posedge clk)
    reset_i && $past(reset_i) |-> !(|init_r_valid_o) && !(|targ_ar_valid_o))
    else
    begin
      fail_count++;
      $error("valid output high during reset");
    end

endmodule

bind axi_read_xbar axi_read_xbar_asserts #(
  .NB_INIT (NB_INIT),
  .NB_TARG (NB_TARG),
  .ADDR_W  (ADDR_W),
  .DATA_W  (DATA_W),
  .ID_W    (ID_W)
) u_asserts (
  .clk             (clk),
  .reset_i         (reset_i),
  .start_addr_i    (start_addr_i),
  .end_addr_i      (end_addr_i),
  .init_r_id_o     (init_r_id_o),
  .init_r_data_o   (init_r_data_o),
  .init_r_resp_o   (init_r_resp_o),
  .init_r_valid_o  (init_r_valid_o),
  .init_r_ready_i  (init_r_ready_i),
  .targ_ar_id_o    (targ_ar_id_o),
  .targ_ar_addr_o  (targ_ar_addr_o),
  .targ_ar_valid_o (targ_ar_valid_o),
  .targ_ar_ready_i (targ_ar_ready_i)
);

// File: verif/axi_read_xbar_tb.sv
// Self-checking testbench for the read crossbar; runs a table of reads from both initiators at once
`timescale 1ns/10ps

module axi_read_xbar_tb;
  import axi_xbar_pkg::*;

  localparam int NB_INIT     = DEF_NB_INIT;
  localparam int NB_TARG     = DEF_NB_TARG;
  localparam int ADDR_W      = DEF_ADDR_W;
  localparam int DATA_W      = DEF_DATA_W;
  localparam int ID_W        = DEF_ID_W;
  localparam int WID_W       = ID_W + idx_width(NB_INIT);
  localparam int NO_TARG     = NB_TARG;
  localparam int NROWS       = 16;
  localparam int CYCLE_LIMIT = 64 * NROWS;
  localparam int FIFO_D      = 8;

  typedef struct packed {
    int                phase;
    int                init;
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    int                tgt;
    logic [DATA_W-1:0] data;
    resp_t             resp;
  } row_t;

  logic                           clk = 1'b0;
  logic                           reset_i;
  logic [NB_TARG-1:0][ADDR_W-1:0] start_addr_i;
  logic [NB_TARG-1:0][ADDR_W-1:0] end_addr_i;
  logic [NB_INIT-1:0][ID_W-1:0]   init_ar_id_i;
  logic [NB_INIT-1:0][ADDR_W-1:0] init_ar_addr_i;
  logic [NB_INIT-1:0]             init_ar_valid_i;
  logic [NB_INIT-1:0]             init_ar_ready_o;
  logic [NB_INIT-1:0][ID_W-1:0]   init_r_id_o;
  logic [NB_INIT-1:0][DATA_W-1:0] init_r_data_o;
  resp_t [NB_INIT-1:0]            init_r_resp_o;
  logic [NB_INIT-1:0]             init_r_valid_o;
  logic [NB_INIT-1:0]             init_r_ready_i;
  logic [NB_TARG-1:0][WID_W-1:0]  targ_ar_id_o;
  logic [NB_TARG-1:0][ADDR_W-1:0] targ_ar_addr_o;
  logic [NB_TARG-1:0]             targ_ar_valid_o;
  logic [NB_TARG-1:0]             targ_ar_ready_i;
  logic [NB_TARG-1:0][WID_W-1:0]  targ_r_id_i;
  logic [NB_TARG-1:0][DATA_W-1:0] targ_r_data_i;
  resp_t [NB_TARG-1:0]            targ_r_resp_i;
  logic [NB_TARG-1:0]             targ_r_valid_i;
  logic [NB_TARG-1:0]             targ_r_ready_o;

  row_t              table_q [NROWS];
  int                row_n;
  logic [31:0]       lcg_state = 32'hdc7d;
  int                seen_tgt [NB_INIT][1 << ID_W];
  logic [WID_W-1:0]  fifo_id [NB_TARG][FIFO_D];
  logic [ADDR_W-1:0] fifo_addr [NB_TARG][FIFO_D];
  int                fifo_due [NB_TARG][FIFO_D];
  int                wr_ptr [NB_TARG];
  int                rd_ptr [NB_TARG];
  int                model_cyc;
  int                timeout_cnt;
  int                rsp_count;

  axi_read_xbar #(
    .NB_INIT (NB_INIT),
    .NB_TARG (NB_TARG),
    .ADDR_W  (ADDR_W),
    .DATA_W  (DATA_W),
    .ID_W    (ID_W)
  ) uut (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Target memory contents rule
  function automatic logic [DATA_W-1:0] target_data(input int tgt, input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] data;
    case (tgt)
      0:       data = addr ^ 32'h5a5a0000;
      1:       data = addr ^ 32'ha5a50000;
      default: data = '0;
    endcase
    return data;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic add_row(input int phase, input int init, input int id,
                         input logic [ADDR_W-1:0] addr, input int tgt);
    table_q[row_n].phase = phase;
    table_q[row_n].init  = init;
    table_q[row_n].id    = ID_W'(id);
    table_q[row_n].addr  = addr;
    table_q[row_n].tgt   = tgt;
    table_q[row_n].data  = target_data(tgt, addr);
    table_q[row_n].resp  = (tgt == NO_TARG) ? RESP_DECERR : RESP_OKAY;
    row_n++;
  endtask

  // Phase 0 has overlapping windows, phase 1 swaps the targets
  task automatic set_ranges(input int phase);
    if (phase == 0)
    begin
      start_addr_i[0] = 32'h1000;
      end_addr_i[0]   = 32'h1fff;
      start_addr_i[1] = 32'h1800;
      end_addr_i[1]   = 32'h2fff;
    end
    else
    begin
      start_addr_i[0] = 32'h2000;
      end_addr_i[0]   = 32'h2fff;
      start_addr_i[1] = 32'h1000;
      end_addr_i[1]   = 32'h1fff;
    end
  endtask

  task automatic run_initiator(input int i, input int phase);
    row_t              row;
    logic [31:0]       rnd;
    logic              got;
    logic [ID_W-1:0]   got_id;
    logic [DATA_W-1:0] got_data;
    resp_t             got_resp;
    for (int r = 0; r < NROWS; r++)
    begin
      row = table_q[r];
      if (row.init == i && row.phase == phase)
      begin
        init_ar_id_i[i]    = row.id;
        init_ar_addr_i[i]  = row.addr;
        init_ar_valid_i[i] = 1'b1;
        do
          @(posedge clk);
        while (!init_ar_ready_o[i]);
        #1;
        init_ar_valid_i[i] = 1'b0;
        got = 1'b0;
        while (!got)
        begin
          rnd = next_random();
          init_r_ready_i[i] = (rnd[18:17] != 2'b00);
          @(posedge clk);
          if (init_r_valid_o[i] && init_r_ready_i[i])
          begin
            got      = 1'b1;
            got_id   = init_r_id_o[i];
            got_data = init_r_data_o[i];
            got_resp = init_r_resp_o[i];
          end
          #1;
        end
        check_value($sformatf("init_r_id_o[%0d]", i), got_id, row.id);
        check_value($sformatf("init_r_data_o[%0d]", i), got_data, row.data);
        check_value($sformatf("init_r_resp_o[%0d]", i), got_resp, row.resp);
        check_value($sformatf("targ_ar_valid_o index for init %0d", i),
                    seen_tgt[i][row.id], row.tgt);
      end
    end
  endtask

  // Target models record the routing and answer after a random latency
  always @(posedge clk)
  begin : target_model
    logic [31:0] rnd;
    int          slot;
    model_cyc++;
    for (int k = 0; k < NB_TARG; k++)
    begin
      if (targ_ar_valid_o[k] && targ_ar_ready_i[k])
      begin
        rnd = next_random();
        slot = wr_ptr[k] % FIFO_D;
        fifo_id[k][slot]   = targ_ar_id_o[k];
        fifo_addr[k][slot] = targ_ar_addr_o[k];
        fifo_due[k][slot]  = model_cyc + 1 + int'(rnd[21:20]);
        wr_ptr[k]++;
        seen_tgt[targ_ar_id_o[k][WID_W-1:ID_W]][targ_ar_id_o[k][ID_W-1:0]] = k;
      end
      if (targ_r_valid_i[k] && targ_r_ready_o[k])
      begin
        rd_ptr[k]++;
      end
    end
    #1;
    for (int k = 0; k < NB_TARG; k++)
    begin
      rnd = next_random();
      targ_ar_ready_i[k] = (rnd[25:24] != 2'b00);
      slot = rd_ptr[k] % FIFO_D;
      if (rd_ptr[k] != wr_ptr[k] && fifo_due[k][slot] <= model_cyc)
      begin
        targ_r_valid_i[k] = 1'b1;
        targ_r_id_i[k]    = fifo_id[k][slot];
        targ_r_data_i[k]  = target_data(k, fifo_addr[k][slot]);
        targ_r_resp_i[k]  = RESP_OKAY;
      end
      else
      begin
        targ_r_valid_i[k] = 1'b0;
      end
    end
  end

  always @(posedge clk)
  begin
    if (!reset_i)
    begin
      for (int i = 0; i < NB_INIT; i++)
      begin
        if (init_r_valid_o[i] && init_r_ready_i[i])
        begin
          rsp_count++;
        end
      end
    end
  end

  // Bound protocol checker counts its assertion failures
  always @(posedge clk)
  begin
    if (uut.u_asserts.fail_count != 0)
    begin
      $display("a protocol assertion on the DUT ports failed before %0t", $time);
      $display("TEST FAILED");
      $fatal(1, "assertion failure");
    end
  end

  always @(posedge clk)
  begin
    timeout_cnt++;
    if (timeout_cnt > CYCLE_LIMIT)
    begin
      $display("timeout: the reads did not complete within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  initial
  begin
    reset_i         = 1'b1;
    init_ar_id_i    = '0;
    init_ar_addr_i  = '0;
    init_ar_valid_i = '0;
    init_r_ready_i  = '0;
    targ_ar_ready_i = '0;
    targ_r_id_i     = '0;
    targ_r_data_i   = '0;
    targ_r_resp_i   = '0;
    targ_r_valid_i  = '0;
    set_ranges(0);
    for (int i = 0; i < NB_INIT; i++)
    begin
      for (int n = 0; n < (1 << ID_W); n++)
      begin
        seen_tgt[i][n] = NO_TARG;
      end
    end
    // Phase, initiator, ID, address, expected target
    add_row(0, 0, 1, 32'h1100, 0);
    add_row(0, 1, 1, 32'h1204, 0);
    add_row(0, 0, 2, 32'h2400, 1);
    add_row(0, 1, 2, 32'h1900, 0);
    add_row(0, 0, 3, 32'h8000, NO_TARG);
    add_row(0, 1, 3, 32'h2abc, 1);
    add_row(0, 0, 4, 32'h1a00, 0);
    add_row(0, 1, 4, 32'h0ffc, NO_TARG);
    add_row(0, 0, 5, 32'h2fff, 1);
    add_row(0, 1, 5, 32'h1000, 0);
    add_row(1, 0, 6, 32'h1100, 1);
    add_row(1, 1, 6, 32'h2400, 0);
    add_row(1, 0, 7, 32'h2800, 0);
    add_row(1, 1, 7, 32'h1204, 1);
    add_row(1, 0, 8, 32'h8000, NO_TARG);
    add_row(1, 1, 8, 32'h3000, NO_TARG);
    repeat (8) @(posedge clk);
    #1;
    reset_i = 1'b0;
    for (int phase = 0; phase < 2; phase++)
    begin
      set_ranges(phase);
      fork
        run_initiator(0, phase);
        run_initiator(1, phase);
      join
    end
    // Idle cycles let any duplicate response show up in the count
    repeat (10) @(posedge clk);
    check_value("init_r_valid_o response count", rsp_count, NROWS);
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: build.f
common/axi_xbar_pkg.sv
common/axi_read_if.sv
request_path/addr_decoder.sv
hdl/rr_arbiter.sv
request_path/ar_request_path.sv
hdl/decerr_responder.sv
hdl/r_response_merge.sv
hdl/axi_read_xbar.sv
verif/axi_read_xbar_asserts.sv
verif/axi_read_xbar_tb.sv
